//--- flist.f
+incdir+src
src/ctrl_pkg.sv
src/snoop_pkg.sv
src/snoop_decode.sv
src/reply_delay.sv
src/snoop_reply_fsm.sv
src/passive_snoop_top.sv
verification/tb_passive_snoop.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the passive snoop testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_passive_snoop -o tb_passive_snoop
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_passive_snoop 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation passed"; then
    exit 0
fi
echo "Pass line not found in simulator output"
exit 1

//--- src/ctrl_pkg.sv
`include "snoop_consts.svh"

package ctrl_pkg;

    // Function field of the control register
    typedef enum logic [3:0]
    {
        FUNC_OSH = 4'd1,  // One-shot delay
        FUNC_CON = 4'd2,  // Continuous delay
        FUNC_ADL = 4'd3,  // Active side, answered as dummy
        FUNC_ADT = 4'd4,
        FUNC_PDT = 4'd5   // Passive data tampering
    } func_e;

    typedef enum logic [3:0]
    {
        TEST_FUZZING  = 4'd0,  // Reply with no inserted wait
        TEST_DELAY_CR = 4'd1   // CRVALID held back by the delay code
    } test_e;

    // Control register as seen by software, en sits in bit 0
    typedef struct packed
    {
        logic       rsvd_hi;       // Bit 21
        logic       pdt_en;
        logic [1:0] rsvd_mid;
        logic       con_en;
        logic       osh_en;
        logic       addr_filt_en;  // Bit 15
        logic       ac_filt_en;
        logic [4:0] crresp;        // Response used by the functions
        func_e      func;
        test_e      test;
        logic       en;
    } ctrl_reg_t;

    typedef struct packed
    {
        logic [3:0]            snoop_match;  // AC snoop type to hit
        logic [`REG_WIDTH-1:0] win_base;
        logic [`REG_WIDTH-1:0] win_size;
    } filter_cfg_t;

endpackage

//--- src/passive_snoop_top.sv
`timescale 1ns/1ps
`include "snoop_consts.svh"

module passive_snoop_top
(
    input  logic                                   ace_aclk,
    input  logic                                   ace_aresetn,
    input  logic                                   i_snoop_valid,
    output logic                                   o_snoop_ready,
    input  snoop_pkg::snoop_req_t                  i_snoop,
    input  ctrl_pkg::ctrl_reg_t                    i_ctrl,
    input  ctrl_pkg::filter_cfg_t                  i_filter,
    input  logic [`REG_WIDTH-1:0]                  i_delay_code,
    input  logic [`LINE_BEATS*`ACE_DATA_WIDTH-1:0] i_cache_line,
    output logic                                   o_crvalid,
    output logic [4:0]                             o_crresp,
    input  logic                                   i_crready,
    output logic                                   o_cdvalid,
    output logic [`ACE_DATA_WIDTH-1:0]             o_cddata,
    output logic                                   o_cdlast,
    input  logic                                   i_cdready,
    output logic                                   o_busy
);

    logic                  cmd_valid;
    logic                  cmd_ready;
    snoop_pkg::reply_cmd_t cmd;
    logic                  delay_start;
    logic                  delay_done;

    // Decode, one command deep
    snoop_decode decode_i
    (
        .ace_aclk      (ace_aclk),
        .ace_aresetn   (ace_aresetn),
        .i_snoop_valid (i_snoop_valid),
        .o_snoop_ready (o_snoop_ready),
        .i_snoop       (i_snoop),
        .i_ctrl        (i_ctrl),
        .i_filter      (i_filter),
        .o_cmd_valid   (cmd_valid),
        .i_cmd_ready   (cmd_ready),
        .o_cmd         (cmd)
    );

    reply_delay delay_i
    (
        .ace_aclk     (ace_aclk),
        .ace_aresetn  (ace_aresetn),
        .i_start      (delay_start),
        .i_delay_code (i_delay_code),
        .o_done       (delay_done)
    );

    // CR and CD drivers
    snoop_reply_fsm reply_i
    (
        .ace_aclk      (ace_aclk),
        .ace_aresetn   (ace_aresetn),
        .i_cmd_valid   (cmd_valid),
        .o_cmd_ready   (cmd_ready),
        .i_cmd         (cmd),
        .i_test        (i_ctrl.test),
        .o_delay_start (delay_start),
        .i_delay_done  (delay_done),
        .i_cache_line  (i_cache_line),
        .o_crvalid     (o_crvalid),
        .o_crresp      (o_crresp),
        .i_crready     (i_crready),
        .o_cdvalid     (o_cdvalid),
        .o_cddata      (o_cddata),
        .o_cdlast      (o_cdlast),
        .i_cdready     (i_cdready),
        .o_busy        (o_busy)
    );

endmodule

//--- src/reply_delay.sv
`timescale 1ns/1ps
`include "snoop_consts.svh"

module reply_delay
(
    input  logic                  ace_aclk,
    input  logic                  ace_aresetn,
    input  logic                  i_start,
    input  logic [`REG_WIDTH-1:0] i_delay_code,
    output logic                  o_done
);

    logic [`REG_WIDTH-1:0] target;
    logic [`REG_WIDTH-1:0] cnt_q;
    logic                  running_q;

    // Zero for code 0, otherwise base << (code - 1)
    assign target = (i_delay_code == '0) ? '0 :
                    (`REG_WIDTH'(`DELAY_BASE_CYCLES) << (i_delay_code - 1'b1));

    // Count of 0 or 1 both finish in the first running cycle
    assign o_done = running_q && (cnt_q <= `REG_WIDTH'(1));

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            running_q <= 1'b0;
            cnt_q     <= '0;
        end
        else if (i_start)
        begin
            running_q <= 1'b1;
            cnt_q     <= target;  // Sampled once per reply
        end
        else if (running_q)
        begin
            if (o_done)
                running_q <= 1'b0;
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // Reply stage only starts the timer from idle
    a_no_restart: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        i_start |-> !running_q);

endmodule

//--- src/snoop_consts.svh
`ifndef SNOOP_CONSTS_SVH
`define SNOOP_CONSTS_SVH

////////////////////////////////////////
// ACE channel widths
////////////////////////////////////////

// Snoop address on the AC channel
`define ACE_ADDR_WIDTH 44

// One CD beat
`define ACE_DATA_WIDTH 128

// Software-visible configuration registers
`define REG_WIDTH 32

////////////////////////////////////////
// Reply shaping
////////////////////////////////////////

`define LINE_BEATS 4  // 64-byte line at 128 bits per beat

// Code d waits DELAY_BASE_CYCLES << (d - 1) cycles, none for d == 0
`define DELAY_BASE_CYCLES 4

`endif

//--- src/snoop_decode.sv
`timescale 1ns/1ps
`include "snoop_consts.svh"

module snoop_decode
(
    input  logic                  ace_aclk,
    input  logic                  ace_aresetn,
    input  logic                  i_snoop_valid,
    output logic                  o_snoop_ready,
    input  snoop_pkg::snoop_req_t i_snoop,
    input  ctrl_pkg::ctrl_reg_t   i_ctrl,
    input  ctrl_pkg::filter_cfg_t i_filter,
    output logic                  o_cmd_valid,
    input  logic                  i_cmd_ready,
    output snoop_pkg::reply_cmd_t o_cmd
);

    logic                     ready_en_q;  // Low for the first cycle out of reset
    logic                     osh_done_q;  // One-shot guard
    logic                     cmd_valid_q;
    snoop_pkg::reply_cmd_t    cmd_q;
    logic [`REG_WIDTH-1:0]    addr_lo;
    logic                     ac_hit;
    logic                     addr_hit;
    logic                     filt_pass;
    logic                     snoop_fire;
    logic                     osh_take;
    snoop_pkg::reply_action_e next_action;

    ////////////////////////////////////////
    // Filters
    ////////////////////////////////////////

    assign addr_lo  = i_snoop.addr[`REG_WIDTH-1:0];
    assign ac_hit   = (i_snoop.snoop == i_filter.snoop_match);
    assign addr_hit = (addr_lo >= i_filter.win_base) &&
                      (addr_lo < i_filter.win_base + i_filter.win_size);

    // Each enabled filter has to hit
    assign filt_pass = (!i_ctrl.ac_filt_en || ac_hit) && (!i_ctrl.addr_filt_en || addr_hit);

    always_comb
    begin
        next_action = snoop_pkg::ACT_DUMMY;
        osh_take    = 1'b0;
        if (filt_pass)
        begin
            case (i_ctrl.func)
                ctrl_pkg::FUNC_OSH:
                begin
                    if (i_ctrl.osh_en && !osh_done_q)
                    begin
                        next_action = snoop_pkg::ACT_DELAYED;
                        osh_take    = 1'b1;  // Arms the guard on handshake
                    end
                end
                ctrl_pkg::FUNC_CON:
                    if (i_ctrl.con_en)
                        next_action = snoop_pkg::ACT_DELAYED;
                ctrl_pkg::FUNC_PDT:
                    if (i_ctrl.pdt_en)
                        next_action = snoop_pkg::ACT_DATA;
                default:
                    next_action = snoop_pkg::ACT_DUMMY;  // ADL, ADT and unknown codes
            endcase
        end
    end

    ////////////////////////////////////////
    // Command register
    ////////////////////////////////////////

    assign o_snoop_ready = ready_en_q && (!cmd_valid_q || i_cmd_ready);
    assign snoop_fire    = i_snoop_valid && o_snoop_ready;
    assign o_cmd_valid   = cmd_valid_q;
    assign o_cmd         = cmd_q;

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            ready_en_q  <= 1'b0;
            osh_done_q  <= 1'b0;
            cmd_valid_q <= 1'b0;
        end
        else
        begin
            ready_en_q <= 1'b1;
            if (!i_ctrl.en)
                osh_done_q <= 1'b0;  // Rearm while disabled
            else if (snoop_fire && osh_take)
                osh_done_q <= 1'b1;
            if (snoop_fire)
                cmd_valid_q <= 1'b1;
            else if (i_cmd_ready)
                cmd_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge ace_aclk)
    begin
        if (snoop_fire)
        begin
            cmd_q.action <= next_action;
            cmd_q.crresp <= i_ctrl.crresp;
            cmd_q.arlen  <= i_snoop.arlen;
        end
    end

    // A decoded command waits unchanged until the reply stage takes it
    a_cmd_hold: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        o_cmd_valid && !i_cmd_ready |=> o_cmd_valid && $stable(o_cmd));

endmodule

//--- src/snoop_pkg.sv
`include "snoop_consts.svh"

package snoop_pkg;

    // One snoop from the interconnect
    typedef struct packed
    {
        logic [`ACE_ADDR_WIDTH-1:0] addr;
        logic [3:0]                 snoop;
        logic [7:0]                 arlen;  // CD burst is arlen + 1 beats
    } snoop_req_t;

    typedef enum logic [1:0]
    {
        ACT_DUMMY   = 2'd0,  // Plain CR with a zero response
        ACT_DELAYED = 2'd1,
        ACT_DATA    = 2'd2   // CR then a CD burst
    } reply_action_e;

    // Decoded command handed to the reply stage
    typedef struct packed
    {
        reply_action_e action;
        logic [4:0]    crresp;
        logic [7:0]    arlen;
    } reply_cmd_t;

    typedef enum logic [2:0]
    {
        ST_IDLE = 3'd0,
        ST_WAIT = 3'd1,  // Delay timer running
        ST_CR   = 3'd2,
        ST_DATA = 3'd3,
        ST_DONE = 3'd4
    } reply_state_e;

endpackage

//--- src/snoop_reply_fsm.sv
`timescale 1ns/1ps
`include "snoop_consts.svh"

module snoop_reply_fsm
(
    input  logic                                   ace_aclk,
    input  logic                                   ace_aresetn,
    input  logic                                   i_cmd_valid,
    output logic                                   o_cmd_ready,
    input  snoop_pkg::reply_cmd_t                  i_cmd,
    input  ctrl_pkg::test_e                        i_test,
    output logic                                   o_delay_start,
    input  logic                                   i_delay_done,
    input  logic [`LINE_BEATS*`ACE_DATA_WIDTH-1:0] i_cache_line,
    output logic                                   o_crvalid,
    output logic [4:0]                             o_crresp,
    input  logic                                   i_crready,
    output logic                                   o_cdvalid,
    output logic [`ACE_DATA_WIDTH-1:0]             o_cddata,
    output logic                                   o_cdlast,
    input  logic                                   i_cdready,
    output logic                                   o_busy
);

    localparam int BEAT_W = $clog2(`LINE_BEATS);

    snoop_pkg::reply_state_e state_q;
    snoop_pkg::reply_cmd_t   cmd_q;      // Command being answered
    logic [BEAT_W-1:0]       beat_q;
    logic [BEAT_W-1:0]       last_beat;
    logic                    cmd_fire;
    logic                    needs_wait;

    assign o_cmd_ready = (state_q == snoop_pkg::ST_IDLE);
    assign cmd_fire    = i_cmd_valid && o_cmd_ready;

    // Only delayed replies in the delay-CR test mode go through the timer
    assign needs_wait    = (i_cmd.action == snoop_pkg::ACT_DELAYED) &&
                           (i_test == ctrl_pkg::TEST_DELAY_CR);
    assign o_delay_start = cmd_fire && needs_wait;

    // Burst clipped to one cache line
    assign last_beat = (cmd_q.arlen >= 8'(`LINE_BEATS - 1)) ? BEAT_W'(`LINE_BEATS - 1)
                                                            : cmd_q.arlen[BEAT_W-1:0];

    ////////////////////////////////////////
    // Channel outputs
    ////////////////////////////////////////

    assign o_crvalid = (state_q == snoop_pkg::ST_CR);
    assign o_crresp  = (cmd_q.action == snoop_pkg::ACT_DUMMY) ? 5'd0 : cmd_q.crresp;
    assign o_cdvalid = (state_q == snoop_pkg::ST_DATA);
    assign o_cddata  = i_cache_line[beat_q*`ACE_DATA_WIDTH +: `ACE_DATA_WIDTH];
    assign o_cdlast  = o_cdvalid && (beat_q == last_beat);
    assign o_busy    = (state_q != snoop_pkg::ST_IDLE);

    ////////////////////////////////////////
    // Reply sequencing
    ////////////////////////////////////////

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            state_q <= snoop_pkg::ST_IDLE;
            beat_q  <= '0;
        end
        else
        begin
            case (state_q)
                snoop_pkg::ST_IDLE:
                begin
                    beat_q <= '0;
                    if (cmd_fire)
                        state_q <= needs_wait ? snoop_pkg::ST_WAIT : snoop_pkg::ST_CR;
                end
                snoop_pkg::ST_WAIT:
                    if (i_delay_done)
                        state_q <= snoop_pkg::ST_CR;
                snoop_pkg::ST_CR:
                begin
                    if (i_crready)  // Tampering goes on to the CD burst
                        state_q <= (cmd_q.action == snoop_pkg::ACT_DATA) ?
                                   snoop_pkg::ST_DATA : snoop_pkg::ST_DONE;
                end
                snoop_pkg::ST_DATA:
                begin
                    if (i_cdready)
                    begin
                        if (beat_q == last_beat)
                            state_q <= snoop_pkg::ST_DONE;
                        else
                            beat_q <= beat_q + 1'b1;  // Next slice of the line
                    end
                end
                snoop_pkg::ST_DONE:
                    state_q <= snoop_pkg::ST_IDLE;
                default:
                    state_q <= snoop_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge ace_aclk)
    begin
        if (cmd_fire)
            cmd_q <= i_cmd;
    end

    // CR response held until the interconnect takes it
    a_cr_hold: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        o_crvalid && !i_crready |=> o_crvalid && $stable(o_crresp));

    // CD beats only ever answer a tampering command from decode
    a_cd_data_only: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        $rose(o_cdvalid) |-> (cmd_q.action == snoop_pkg::ACT_DATA));

endmodule

//--- verification/tb_passive_snoop.sv
`timescale 1ns/1ps
`include "snoop_consts.svh"

module tb_passive_snoop;

    localparam int LINE_W  = `LINE_BEATS * `ACE_DATA_WIDTH;
    localparam int N_RAND  = 24;    // Snoops in the back-pressure run
    localparam int TIMEOUT = 1000;  // Cycles allowed for any single wait

    localparam logic [4:0]                 CRRESP    = 5'h15;
    localparam logic [3:0]                 SNP_HIT   = 4'h7;
    localparam logic [`ACE_ADDR_WIDTH-1:0] ADDR_IN   = 44'h0ab_4000_0040;
    localparam logic [`ACE_ADDR_WIDTH-1:0] ADDR_OUT  = 44'h0ab_5000_0040;

    logic                          ace_aclk;
    logic                          ace_aresetn;
    logic                          snoop_valid;
    logic                          snoop_ready;
    snoop_pkg::snoop_req_t         snoop;
    ctrl_pkg::ctrl_reg_t           ctrl;
    ctrl_pkg::filter_cfg_t         filter;
    logic [`REG_WIDTH-1:0]         delay_code;
    logic [LINE_W-1:0]             cache_line;
    logic                          crvalid;
    logic [4:0]                    crresp;
    logic                          crready;
    logic                          cdvalid;
    logic [`ACE_DATA_WIDTH-1:0]    cddata;
    logic                          cdlast;
    logic                          cdready;
    logic                          busy;

    integer     seed = 32'hfabe_ec06;
    logic       stall_en;
    string      test_name;
    logic [4:0] exp_resp_q[$];   // Expected replies in issue order
    int         exp_beats_q[$];
    int         cd_left;         // Beats still owed by the current reply
    int         beat_idx;
    int         sent_cnt;
    int         done_cnt;
    logic [7:0] rnd_arlen [N_RAND];
    logic       rnd_hit [N_RAND];
    int         rnd_gap [N_RAND];

    passive_snoop_top dut_i
    (
        .ace_aclk      (ace_aclk),
        .ace_aresetn   (ace_aresetn),
        .i_snoop_valid (snoop_valid),
        .o_snoop_ready (snoop_ready),
        .i_snoop       (snoop),
        .i_ctrl        (ctrl),
        .i_filter      (filter),
        .i_delay_code  (delay_code),
        .i_cache_line  (cache_line),
        .o_crvalid     (crvalid),
        .o_crresp      (crresp),
        .i_crready     (crready),
        .o_cdvalid     (cdvalid),
        .o_cddata      (cddata),
        .o_cdlast      (cdlast),
        .i_cdready     (cdready),
        .o_busy        (busy)
    );

    always #5 ace_aclk = ~ace_aclk;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_eq(input string field, input logic [127:0] expected,
                            input logic [127:0] actual);
        assert (actual === expected)
        else
        begin
            $display("Mismatch in %s (%s): expected %0h, actual %0h",
                     test_name, field, expected, actual);
            stop_run();
        end
    endtask

    // CD beats owed for a tampering reply within one line
    function automatic int burst_beats(input logic [7:0] arlen);
        return (arlen >= `LINE_BEATS) ? `LINE_BEATS : int'(arlen) + 1;
    endfunction

    task automatic send_snoop(input logic [`ACE_ADDR_WIDTH-1:0] addr, input logic [3:0] snp,
                              input logic [7:0] arlen, input logic [4:0] resp,
                              input int beats, input int gap);
        int waited;
        waited = 0;
        repeat (gap)
        begin
            @(posedge ace_aclk);
            #1;
        end
        snoop.addr  = addr;
        snoop.snoop = snp;
        snoop.arlen = arlen;
        snoop_valid = 1'b1;
        exp_resp_q.push_back(resp);
        exp_beats_q.push_back(beats);
        sent_cnt++;
        @(negedge ace_aclk);
        while (!snoop_ready)
        begin
            if (waited == TIMEOUT)
            begin
                $display("Timeout in %s: snoop never accepted", test_name);
                stop_run();
            end
            else
            begin
                waited++;
                @(negedge ace_aclk);
            end
        end
        @(posedge ace_aclk);  // Handshake edge
        #1;
        snoop_valid = 1'b0;
    endtask

    // Clock edges from the handshake edge to the one that raises crvalid
    task automatic measure_cr_latency(output int cycles);
        cycles = 0;
        @(negedge ace_aclk);
        while (!crvalid)
        begin
            if (cycles == TIMEOUT)
            begin
                $display("Timeout in %s: crvalid never rose", test_name);
                stop_run();
            end
            else
            begin
                cycles++;
                @(negedge ace_aclk);
            end
        end
        @(posedge ace_aclk);
        #1;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (exp_resp_q.size() != 0 || cd_left != 0 || busy)
        begin
            if (waited == TIMEOUT)
            begin
                $display("Timeout in %s: replies still outstanding", test_name);
                stop_run();
            end
            else
            begin
                waited++;
                @(posedge ace_aclk);
                #1;
            end
        end
    endtask

    ////////////////////////////////////////
    // Ready drivers and reply monitor
    ////////////////////////////////////////

    always @(posedge ace_aclk)
    begin
        #1;
        if (stall_en)
        begin
            crready = (($random(seed) & 3) != 0);  // Low about a quarter of the time
            cdready = (($random(seed) & 3) != 0);
        end
        else
        begin
            crready = 1'b1;
            cdready = 1'b1;
        end
    end

    always @(negedge ace_aclk)
    begin
        logic [4:0] want_resp;
        if (ace_aresetn)
        begin
            if (cdvalid && cd_left == 0)
            begin
                $display("CD valid raised in %s for a reply without data", test_name);
                stop_run();
            end
            else if (cdvalid && cdready)
            begin
                check_eq("cddata", cache_line[beat_idx*`ACE_DATA_WIDTH +: `ACE_DATA_WIDTH],
                         cddata);
                check_eq("cdlast", (cd_left == 1), cdlast);
                beat_idx++;
                cd_left--;
                if (cd_left == 0)
                    done_cnt++;
            end
            else if (crvalid && crready)
            begin
                if (exp_resp_q.size() == 0)
                begin
                    $display("CR handshake in %s with no snoop outstanding", test_name);
                    stop_run();
                end
                else
                begin
                    want_resp = exp_resp_q.pop_front();
                    cd_left   = exp_beats_q.pop_front();
                    beat_idx  = 0;
                    check_eq("crresp", want_resp, crresp);
                    if (cd_left == 0)
                        done_cnt++;  // No burst follows
                end
            end
        end
    end

    // Beat payload held while the interconnect stalls
    a_cd_hold: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        cdvalid && !cdready |=> cdvalid && $stable(cddata) && $stable(cdlast))
    else
    begin
        $display("CD beat changed before cdready in %s", test_name);
        stop_run();
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        int lat;
        int k;
        ace_aclk    = 1'b0;
        ace_aresetn = 1'b0;
        snoop_valid = 1'b0;
        snoop       = '0;
        delay_code  = '0;
        crready     = 1'b1;
        cdready     = 1'b1;
        stall_en    = 1'b0;
        cd_left     = 0;
        beat_idx    = 0;
        sent_cnt    = 0;
        done_cnt    = 0;
        test_name   = "reset";
        ctrl              = '0;
        ctrl.en           = 1'b1;
        ctrl.crresp       = CRRESP;
        ctrl.func         = ctrl_pkg::FUNC_PDT;
        ctrl.test         = ctrl_pkg::TEST_FUZZING;
        ctrl.pdt_en       = 1'b1;
        ctrl.ac_filt_en   = 1'b1;
        ctrl.addr_filt_en = 1'b1;
        filter.snoop_match = SNP_HIT;
        filter.win_base    = 32'h4000_0000;
        filter.win_size    = 32'h0000_1000;
        for (k = 0; k < LINE_W / 32; k++)
            cache_line[k*32 +: 32] = $random(seed);
        for (k = 0; k < N_RAND; k++)
        begin
            rnd_arlen[k] = 8'($random(seed) & 7);
            rnd_hit[k]   = (($random(seed) & 1) != 0);
            rnd_gap[k]   = $random(seed) & 3;
        end

        repeat (3) @(posedge ace_aclk);
        #1;
        check_eq("outputs in reset", '0, {snoop_ready, crvalid, cdvalid, cdlast, busy});
        ace_aresetn = 1'b1;

        test_name = "filter_miss";
        send_snoop(ADDR_IN, 4'h3, 8'd3, 5'd0, 0, 0);   // Wrong snoop type
        send_snoop(ADDR_OUT, SNP_HIT, 8'd3, 5'd0, 0, 0);
        wait_idle();

        test_name = "pdt_burst";
        send_snoop(ADDR_IN, SNP_HIT, 8'd0, CRRESP, burst_beats(8'd0), 0);
        send_snoop(ADDR_IN, SNP_HIT, 8'd3, CRRESP, burst_beats(8'd3), 0);
        wait_idle();

        test_name   = "one_shot";
        ctrl.func   = ctrl_pkg::FUNC_OSH;
        ctrl.osh_en = 1'b1;
        send_snoop(ADDR_IN, SNP_HIT, 8'd0, CRRESP, 0, 0);
        send_snoop(ADDR_IN, SNP_HIT, 8'd0, 5'd0, 0, 0);
        send_snoop(ADDR_IN, SNP_HIT, 8'd0, 5'd0, 0, 0);
        wait_idle();
        ctrl.en = 1'b0;  // Rearms the guard
        @(posedge ace_aclk);
        #1;
        ctrl.en = 1'b1;
        send_snoop(ADDR_IN, SNP_HIT, 8'd0, CRRESP, 0, 0);
        wait_idle();

        test_name   = "continuous_delay";
        ctrl.func   = ctrl_pkg::FUNC_CON;
        ctrl.con_en = 1'b1;
        ctrl.test   = ctrl_pkg::TEST_DELAY_CR;
        delay_code  = 32'd3;
        send_snoop(ADDR_IN, SNP_HIT, 8'd0, CRRESP, 0, 0);
        measure_cr_latency(lat);
        assert (lat >= (`DELAY_BASE_CYCLES << 2))
        else
        begin
            $display("Mismatch in %s (cr latency): expected at least %0d, actual %0d",
                     test_name, `DELAY_BASE_CYCLES << 2, lat);
            stop_run();
        end
        wait_idle();
        ctrl.test = ctrl_pkg::TEST_FUZZING;
        send_snoop(ADDR_IN, SNP_HIT, 8'd0, CRRESP, 0, 0);
        wait_idle();

        test_name = "back_pressure";
        ctrl.func = ctrl_pkg::FUNC_PDT;
        stall_en  = 1'b1;
        for (k = 0; k < N_RAND; k++)
        begin
            if (rnd_hit[k])
                send_snoop(ADDR_IN, SNP_HIT, rnd_arlen[k], CRRESP, burst_beats(rnd_arlen[k]),
                           rnd_gap[k]);
            else
                send_snoop(ADDR_OUT, SNP_HIT, rnd_arlen[k], 5'd0, 0, rnd_gap[k]);
        end
        wait_idle();
        stall_en = 1'b0;

        if (done_cnt == sent_cnt && exp_resp_q.size() == 0)
        begin
            $display("Simulation passed");
            $finish;
        end
        else
        begin
            $display("Replies missing at the end of the run: %0d of %0d", done_cnt, sent_cnt);
            stop_run();
        end
    end

endmodule
